// ==== files.f ====
+incdir+source
source/lpif_pkg.sv
source/lpif_lsm.sv
source/lpif_tx_framer.sv
source/lpif_rx_deframer.sv
source/lpif_adapter.sv
testbench/tb_clock_gen.sv
testbench/lpif_adapter_tb.sv

// ==== Makefile ====
# Verilator build and run of the LPIF adapter testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f files.f --top-module lpif_adapter_tb -o lpif_sim
	out=$$(./obj_dir/lpif_sim 2>&1); echo "$$out"; \
		echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

// ==== testbench/lpif_adapter_tb.sv ====
`timescale 1ns/100ps
`include "lpif_macros.svh"

module lpif_adapter_tb;

  localparam int PL            = `AIB_PAYLOAD_BITS;
  localparam int DRIVE_DELAY   = 10;   // Stimulus slot after each rising edge
  localparam int RESET_TIMEOUT = 20;
  localparam int LINK_TIMEOUT  = 20;
  localparam int LPBK_CYCLES   = 60;
  localparam int DRAIN_CYCLES  = 3;
  localparam int STALL_HOLD    = 3;

  logic                  lclk;
  logic                  arst_n;
  logic                  lp_irdy;
  lpif_pkg::lpif_flit_t  lp_flit;
  logic                  pl_trdy;
  logic                  pl_valid;
  lpif_pkg::lpif_flit_t  pl_flit;
  logic                  pl_error;
  lpif_pkg::lpif_state_e lp_state_req;
  lpif_pkg::lpif_state_e pl_state_sts;
  logic                  pl_stallreq;
  logic                  lp_stallack;
  logic                  pl_lnk_up;
  logic                  pl_phyinl1;
  logic                  fs_mac_rdy;
  logic                  lpbk_en;
  lpif_pkg::lane_frame_t dout;
  lpif_pkg::lane_frame_t data_in_f;

  logic [31:0]          rng;
  int                   cycle;
  lpif_pkg::lpif_flit_t exp_flits[$];   // Reference model of the flits in flight
  int                   exp_stamps[$];  // Cycle each flit was driven

  tb_clock_gen clock_gen_i (
    .lclk   (lclk),
    .arst_n (arst_n)
  );

  lpif_adapter dut_i (
    .lclk         (lclk),
    .arst_n       (arst_n),
    .lp_irdy      (lp_irdy),
    .lp_flit      (lp_flit),
    .pl_trdy      (pl_trdy),
    .pl_valid     (pl_valid),
    .pl_flit      (pl_flit),
    .pl_error     (pl_error),
    .lp_state_req (lp_state_req),
    .pl_state_sts (pl_state_sts),
    .pl_stallreq  (pl_stallreq),
    .lp_stallack  (lp_stallack),
    .pl_lnk_up    (pl_lnk_up),
    .pl_phyinl1   (pl_phyinl1),
    .fs_mac_rdy   (fs_mac_rdy),
    .lpbk_en      (lpbk_en),
    .dout         (dout),
    .data_in_f    (data_in_f)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Expected lane words with valid bit, flit, two zero bits and even parity per lane
  function automatic logic [79:0] pack_frame(input logic vld, input lpif_pkg::lpif_flit_t f);
    logic [2*PL-1:0] bits;
    logic [79:0]     frame;
    bits               = {2'b00, f, vld};
    frame[PL-1:0]      = bits[PL-1:0];
    frame[PL]          = ^bits[PL-1:0];
    frame[2*PL:PL+1]   = bits[2*PL-1:PL];
    frame[2*PL+1]      = ^bits[2*PL-1:PL];
    return frame;
  endfunction

  task automatic make_flit(input int idx, output lpif_pkg::lpif_flit_t f);
    rng = xorshift32(rng);
    f.data[31:0] = rng;
    rng = xorshift32(rng);
    f.data[63:32] = rng;
    rng = xorshift32(rng);
    f.valid = rng[7:0];
    case (idx % 3)  // Walk through all three streams
      0:       f.stream = lpif_pkg::MEM_CACHE;
      1:       f.stream = lpif_pkg::IO;
      default: f.stream = lpif_pkg::ARB_MUX;
    endcase
  endtask

  task automatic next_cycle();
    @(posedge lclk);
    #DRIVE_DELAY;
    cycle++;
  endtask

  task automatic abort_run();
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out while waiting for %s", what);
    abort_run();
  endtask

  task automatic check_bit(input string test, input logic expected, input logic actual);
    assert (actual === expected)
    else
    begin
      $display("Fail %s: expected %b, actual %b", test, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_state(input string test, input lpif_pkg::lpif_state_e expected,
                             input lpif_pkg::lpif_state_e actual);
    assert (actual === expected)
    else
    begin
      $display("Fail %s: expected %b, actual %b", test, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_value(input string test, input logic [79:0] expected,
                             input logic [79:0] actual);
    assert (actual === expected)
    else
    begin
      $display("Fail %s: expected %h, actual %h", test, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_reset_outputs(input string test);
    check_bit(test, 1'b0, pl_trdy);
    check_bit(test, 1'b0, pl_stallreq);
    check_bit(test, 1'b0, pl_lnk_up);
    check_bit(test, 1'b0, pl_phyinl1);
    check_bit(test, 1'b0, pl_valid);
    check_bit(test, 1'b0, pl_error);
    check_state(test, lpif_pkg::RESET, pl_state_sts);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus

  initial
  begin
    lpif_pkg::lpif_flit_t flit;
    lpif_pkg::lpif_flit_t last_flit;
    lpif_pkg::lpif_flit_t prev_flit;
    logic                 last_acc;
    logic                 prev_acc;
    logic [79:0]          frame;
    int                   n;
    int                   n_sent;

    lp_irdy      = 1'b0;
    lp_flit      = '0;
    lp_state_req = lpif_pkg::NOP;
    lp_stallack  = 1'b0;
    fs_mac_rdy   = 1'b0;
    lpbk_en      = 1'b0;
    dout         = '0;
    rng          = 32'h0c1d_d5f1;
    cycle        = 0;

    // Reset
    for (n = 0; n < RESET_TIMEOUT && !arst_n; n++)
    begin
      next_cycle();
      check_reset_outputs("reset");
    end
    if (!arst_n)
      report_timeout("reset release");
    next_cycle();
    check_reset_outputs("after reset");

    // Bring-up
    fs_mac_rdy   = 1'b1;
    lp_state_req = lpif_pkg::ACTIVE;
    for (n = 0; n < LINK_TIMEOUT && pl_state_sts != lpif_pkg::ACTIVE; n++)
      next_cycle();
    if (pl_state_sts != lpif_pkg::ACTIVE)
      report_timeout("ACTIVE status");
    check_bit("bring-up lnk_up", 1'b1, pl_lnk_up);
    check_bit("bring-up trdy", 1'b1, pl_trdy);

    // Loopback with random flits and random gaps
    lpbk_en   = 1'b1;
    last_acc  = 1'b0;
    last_flit = '0;
    prev_acc  = 1'b0;
    prev_flit = '0;
    n_sent    = 0;
    for (int i = 0; i < LPBK_CYCLES + DRAIN_CYCLES; i++)
    begin
      // Frame of the flit taken two edges back
      check_value("loopback frame", pack_frame(prev_acc, prev_flit), 80'(data_in_f));
      check_bit("loopback error", 1'b0, pl_error);
      if (exp_stamps.size() > 0 && exp_stamps[0] + 3 == cycle)
      begin
        check_bit("loopback valid", 1'b1, pl_valid);
        check_value("loopback flit", 80'(exp_flits[0]), 80'(pl_flit));
        void'(exp_flits.pop_front());
        void'(exp_stamps.pop_front());
      end
      else
        check_bit("loopback idle", 1'b0, pl_valid);

      rng = xorshift32(rng);
      lp_irdy = (i < LPBK_CYCLES) && (rng[1:0] != 2'b00);
      make_flit(n_sent, flit);
      lp_flit   = flit;
      prev_acc  = last_acc;
      prev_flit = last_flit;
      last_acc  = lp_irdy && pl_trdy;  // Taken at the coming edge
      last_flit = last_acc ? flit : '0;
      if (last_acc)
      begin
        exp_flits.push_back(flit);
        exp_stamps.push_back(cycle);
        n_sent++;
      end
      next_cycle();
    end
    assert (exp_flits.size() == 0)
    else
    begin
      $display("Loopback flits were sent but never came back");
      abort_run();
    end

    // Parity on the AIB receive path
    lpbk_en = 1'b0;
    make_flit(0, flit);
    frame = pack_frame(1'b1, flit);
    dout  = frame;
    next_cycle();
    check_bit("parity good valid", 1'b1, pl_valid);
    check_bit("parity good error", 1'b0, pl_error);
    check_value("parity good flit", 80'(flit), 80'(pl_flit));

    rng  = xorshift32(rng);
    dout = frame ^ (80'd1 << (rng % 39));       // Lane 0 payload bit
    next_cycle();
    check_bit("lane 0 error", 1'b1, pl_error);
    check_bit("lane 0 valid", 1'b0, pl_valid);

    rng  = xorshift32(rng);
    dout = frame ^ (80'd1 << (40 + rng % 39));  // Lane 1 payload bit
    next_cycle();
    check_bit("lane 1 error", 1'b1, pl_error);
    check_bit("lane 1 valid", 1'b0, pl_valid);

    dout = '0;
    next_cycle();
    check_bit("idle error", 1'b0, pl_error);

    // Stall exchange into L1
    lp_state_req = lpif_pkg::IDLE_L1;
    next_cycle();
    for (n = 0; n <= STALL_HOLD; n++)
    begin
      check_bit("stall stallreq", 1'b1, pl_stallreq);
      check_bit("stall trdy", 1'b0, pl_trdy);
      check_state("stall status", lpif_pkg::ACTIVE, pl_state_sts);
      if (n < STALL_HOLD)
        next_cycle();
    end
    lp_stallack = 1'b1;
    next_cycle();
    check_state("L1 status", lpif_pkg::IDLE_L1, pl_state_sts);
    check_bit("L1 phyinl1", 1'b1, pl_phyinl1);
    check_bit("L1 stallreq", 1'b0, pl_stallreq);

    // Ack still high, so the ACTIVE request has to wait
    lp_state_req = lpif_pkg::ACTIVE;
    for (n = 0; n < STALL_HOLD; n++)
    begin
      next_cycle();
      check_state("L1 hold", lpif_pkg::IDLE_L1, pl_state_sts);
    end
    lp_stallack = 1'b0;
    next_cycle();
    check_state("L1 exit status", lpif_pkg::ACTIVE, pl_state_sts);
    check_bit("L1 exit trdy", 1'b1, pl_trdy);
    check_bit("L1 exit phyinl1", 1'b0, pl_phyinl1);

    // Link loss
    fs_mac_rdy = 1'b0;
    next_cycle();
    check_state("link loss status", lpif_pkg::RESET, pl_state_sts);
    check_bit("link loss lnk_up", 1'b0, pl_lnk_up);
    check_bit("link loss trdy", 1'b0, pl_trdy);

    $display("Regression passed");
    $finish;
  end

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
  output logic lclk,
  output logic arst_n
);

  localparam int HALF_PERIOD = 50;   // 100 ns clock
  localparam int RESET_CYCLES = 10;

  initial
  begin
    lclk = 1'b0;
    forever #HALF_PERIOD lclk = ~lclk;
  end

  // Release comes a little after the edge, before the stimulus slot
  initial
  begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge lclk);
    #5 arst_n = 1'b1;
  end

endmodule

// ==== source/lpif_adapter.sv ====
`timescale 1ns/100ps

module lpif_adapter (
  input  logic                  lclk,
  input  logic                  arst_n,

  // LPIF transmit
  input  logic                  lp_irdy,
  input  lpif_pkg::lpif_flit_t  lp_flit,
  output logic                  pl_trdy,

  // LPIF receive
  output logic                  pl_valid,
  output lpif_pkg::lpif_flit_t  pl_flit,
  output logic                  pl_error,

  // LPIF state
  input  lpif_pkg::lpif_state_e lp_state_req,
  output lpif_pkg::lpif_state_e pl_state_sts,
  output logic                  pl_stallreq,
  input  logic                  lp_stallack,
  output logic                  pl_lnk_up,
  output logic                  pl_phyinl1,

  // AIB side
  input  logic                  fs_mac_rdy,
  input  logic                  lpbk_en,
  input  lpif_pkg::lane_frame_t dout,
  output lpif_pkg::lane_frame_t data_in_f
);

  ////////////////////////////////////////////////////////////////////////////
  // Link state machine

  lpif_lsm lpif_lsm_i (
    .lclk         (lclk),
    .arst_n       (arst_n),
    .lp_state_req (lp_state_req),
    .pl_state_sts (pl_state_sts),
    .pl_stallreq  (pl_stallreq),
    .lp_stallack  (lp_stallack),
    .fs_mac_rdy   (fs_mac_rdy),
    .pl_trdy      (pl_trdy),
    .pl_lnk_up    (pl_lnk_up),
    .pl_phyinl1   (pl_phyinl1)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Datapath

  lpif_tx_framer lpif_tx_framer_i (
    .lclk      (lclk),
    .arst_n    (arst_n),
    .tx_enable (pl_trdy),  // Same net the link layer sees
    .lp_irdy   (lp_irdy),
    .lp_flit   (lp_flit),
    .data_in_f (data_in_f)
  );

  lpif_rx_deframer lpif_rx_deframer_i (
    .lclk      (lclk),
    .arst_n    (arst_n),
    .lpbk_en   (lpbk_en),
    .data_in_f (data_in_f),
    .dout      (dout),
    .pl_valid  (pl_valid),
    .pl_flit   (pl_flit),
    .pl_error  (pl_error)
  );

endmodule

// ==== source/lpif_rx_deframer.sv ====
`timescale 1ns/100ps
`include "lpif_macros.svh"

module lpif_rx_deframer (
  input  logic                  lclk,
  input  logic                  arst_n,

  input  logic                  lpbk_en,
  input  lpif_pkg::lane_frame_t data_in_f,  // Our own transmit frame
  input  lpif_pkg::lane_frame_t dout,       // From AIB

  output logic                  pl_valid,
  output lpif_pkg::lpif_flit_t  pl_flit,
  output logic                  pl_error
);

  lpif_pkg::lane_frame_t          rx_frame;
  logic [`FRAME_PAYLOAD_BITS-1:0] payload_bits;
  lpif_pkg::lane_payload_t        payload;
  logic [`AIB_LANES-1:0]          lane_err;
  logic                           par_err;

  ////////////////////////////////////////////////////////////////////////////
  // Source select and parity check

  // Loopback turns the transmit frame straight around
  assign rx_frame = lpbk_en ? data_in_f : dout;

  always_comb
  begin
    for (int i = 0; i < `AIB_LANES; i++)
    begin
      payload_bits[i*`AIB_PAYLOAD_BITS +: `AIB_PAYLOAD_BITS] = rx_frame.lanes[i].payload;
      lane_err[i] =
        rx_frame.lanes[i].parity != lpif_pkg::even_parity(rx_frame.lanes[i].payload);
    end
  end

  assign payload = payload_bits;
  assign par_err = |lane_err;  // Any bad lane kills the whole flit

  ////////////////////////////////////////////////////////////////////////////
  // Registered outputs

  always_ff @(posedge lclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pl_valid <= 1'b0;
      pl_error <= 1'b0;
    end
    else
    begin
      pl_error <= par_err;
      pl_valid <= payload.flit_vld & ~par_err;
    end
  end

  // Data only, qualified by pl_valid
  always_ff @(posedge lclk)
  begin
    if (payload.flit_vld && !par_err)
      pl_flit <= payload.flit;
  end

endmodule

// ==== source/lpif_tx_framer.sv ====
`timescale 1ns/100ps
`include "lpif_macros.svh"

module lpif_tx_framer (
  input  logic                  lclk,
  input  logic                  arst_n,

  input  logic                  tx_enable,  // pl_trdy from the LSM
  input  logic                  lp_irdy,
  input  lpif_pkg::lpif_flit_t  lp_flit,

  output lpif_pkg::lane_frame_t data_in_f   // To AIB
);

  logic                           accept;
  logic                           acc_q;     // Flit taken at the last edge
  lpif_pkg::lpif_flit_t           flit_q;
  lpif_pkg::lane_payload_t        payload;
  logic [`FRAME_PAYLOAD_BITS-1:0] payload_bits;
  lpif_pkg::lane_frame_t          frame_nxt;

  assign accept = tx_enable & lp_irdy;

  // Input stage holding the accepted flit
  always_ff @(posedge lclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      acc_q  <= 1'b0;
      flit_q <= '0;
    end
    else
    begin
      acc_q  <= accept;
      flit_q <= lp_flit;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Payload build

  always_comb
  begin
    payload = '0;  // Idle frame unless a flit is taken
    if (acc_q)
    begin
      payload.flit_vld = 1'b1;
      payload.flit     = flit_q;
    end
  end

  assign payload_bits = payload;

  // Split over lanes and add parity
  always_comb
  begin
    for (int i = 0; i < `AIB_LANES; i++)
    begin
      frame_nxt.lanes[i].payload =
        payload_bits[i*`AIB_PAYLOAD_BITS +: `AIB_PAYLOAD_BITS];
      frame_nxt.lanes[i].parity  =
        lpif_pkg::even_parity(payload_bits[i*`AIB_PAYLOAD_BITS +: `AIB_PAYLOAD_BITS]);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register

  // All zeros is itself a valid idle frame
  always_ff @(posedge lclk or negedge arst_n)
  begin
    if (!arst_n)
      data_in_f <= '0;
    else
      data_in_f <= frame_nxt;
  end

endmodule

// ==== source/lpif_lsm.sv ====
`timescale 1ns/100ps

module lpif_lsm (
  input  logic                  lclk,
  input  logic                  arst_n,

  // Link layer state interface
  input  lpif_pkg::lpif_state_e lp_state_req,
  output lpif_pkg::lpif_state_e pl_state_sts,

  // Stall handshake
  output logic                  pl_stallreq,
  input  logic                  lp_stallack,

  // Far side readiness
  input  logic                  fs_mac_rdy,

  output logic                  pl_trdy,     // Transmit enable
  output logic                  pl_lnk_up,
  output logic                  pl_phyinl1
);

  lpif_pkg::lsm_state_e state;
  lpif_pkg::lsm_state_e state_nxt;
  lpif_pkg::lsm_state_e stall_target;  // Where to go once the stall is acked
  lpif_pkg::lsm_state_e target_nxt;

  ////////////////////////////////////////////////////////////////////////////
  // Next state

  always_comb
  begin
    state_nxt  = state;
    target_nxt = stall_target;

    if (!fs_mac_rdy)
      state_nxt = lpif_pkg::LSM_RESET;  // Link loss wins from any state
    else
    begin
      case (state)
        lpif_pkg::LSM_RESET:
        begin
          if (lp_state_req == lpif_pkg::ACTIVE)
            state_nxt = lpif_pkg::LSM_ACTIVE;
        end

        lpif_pkg::LSM_ACTIVE:
        begin
          // Leaving ACTIVE always goes through the stall exchange
          if (lp_state_req == lpif_pkg::IDLE_L1)
          begin
            state_nxt  = lpif_pkg::LSM_STALL;
            target_nxt = lpif_pkg::LSM_IDLE_L1;
          end
          else if (lp_state_req == lpif_pkg::RETRAIN)
          begin
            state_nxt  = lpif_pkg::LSM_STALL;
            target_nxt = lpif_pkg::LSM_RETRAIN;
          end
        end

        lpif_pkg::LSM_STALL:
        begin
          if (lp_stallack)
            state_nxt = stall_target;
        end

        lpif_pkg::LSM_IDLE_L1,
        lpif_pkg::LSM_RETRAIN:
        begin
          // Wait for the ack to drop, closing the four-phase exchange
          if (lp_state_req == lpif_pkg::ACTIVE && !lp_stallack)
            state_nxt = lpif_pkg::LSM_ACTIVE;
        end

        default:
          state_nxt = lpif_pkg::LSM_RESET;
      endcase
    end
  end

  always_ff @(posedge lclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state        <= lpif_pkg::LSM_RESET;
      stall_target <= lpif_pkg::LSM_IDLE_L1;
    end
    else
    begin
      state        <= state_nxt;
      stall_target <= target_nxt;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs decoded straight from the state register

  assign pl_trdy     = (state == lpif_pkg::LSM_ACTIVE);
  assign pl_lnk_up   = (state == lpif_pkg::LSM_ACTIVE);
  assign pl_stallreq = (state == lpif_pkg::LSM_STALL);
  assign pl_phyinl1  = (state == lpif_pkg::LSM_IDLE_L1);

  always_comb
  begin
    case (state)
      lpif_pkg::LSM_ACTIVE,
      lpif_pkg::LSM_STALL:   pl_state_sts = lpif_pkg::ACTIVE;  // Still active to the link layer
      lpif_pkg::LSM_IDLE_L1: pl_state_sts = lpif_pkg::IDLE_L1;
      lpif_pkg::LSM_RETRAIN: pl_state_sts = lpif_pkg::RETRAIN;
      default:               pl_state_sts = lpif_pkg::RESET;
    endcase
  end

endmodule

// ==== source/lpif_pkg.sv ====
`include "lpif_macros.svh"

package lpif_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings

  // LPIF state request / status codes
  typedef enum logic [3:0] {
    NOP     = 4'b0000,
    ACTIVE  = 4'b0001,
    IDLE_L1 = 4'b0100,
    RESET   = 4'b1001,
    RETRAIN = 4'b1011
  } lpif_state_e;

  typedef enum logic [2:0] {
    MEM_CACHE = 3'b001,
    IO        = 3'b010,
    ARB_MUX   = 3'b100
  } lpif_stream_e;

  // STALL sits between ACTIVE and a low-power or retrain state
  typedef enum logic [2:0] {
    LSM_RESET,
    LSM_ACTIVE,
    LSM_STALL,
    LSM_IDLE_L1,
    LSM_RETRAIN
  } lsm_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Flit and frame layout

  typedef struct packed {
    logic [`LPIF_DATA_BITS-1:0]  data;
    logic [`LPIF_DATA_BYTES-1:0] valid;   // Byte enables
    lpif_stream_e                stream;
  } lpif_flit_t;

  // Frame payload before it is split over the lanes
  typedef struct packed {
    logic [`FRAME_PAYLOAD_BITS-$bits(lpif_flit_t)-2:0] rsvd;  // Always zero
    lpif_flit_t                                        flit;
    logic                                              flit_vld;
  } lane_payload_t;

  typedef struct packed {
    logic                         parity;  // Even parity over payload
    logic [`AIB_PAYLOAD_BITS-1:0] payload;
  } lane_word_t;

  typedef struct packed {
    lane_word_t [`AIB_LANES-1:0] lanes;  // Lane 0 holds the low payload bits
  } lane_frame_t;

  // Parity bit that makes the whole lane word even
  function automatic logic even_parity(input logic [`AIB_PAYLOAD_BITS-1:0] bits);
    return ^bits;
  endfunction

endpackage

// ==== source/lpif_macros.svh ====
`ifndef LPIF_MACROS_SVH
`define LPIF_MACROS_SVH

// Flit size on the LPIF side
`define LPIF_DATA_BYTES 8
`define LPIF_DATA_BITS (`LPIF_DATA_BYTES * 8)

// AIB lane layout
`define AIB_LANES 2
`define AIB_BITS_PER_LANE 40

// One bit of every lane word carries parity, the rest is payload
`define AIB_PAYLOAD_BITS (`AIB_BITS_PER_LANE - 1)

// Payload bits across all lanes of one frame
`define FRAME_PAYLOAD_BITS (`AIB_LANES * `AIB_PAYLOAD_BITS)

`endif
